// File: all.f
source/icache_pkg.sv
source/icache_way.sv
source/icache_ctrl.sv
source/icache_resp.sv
source/icache_top.sv
test/icache_mem_model.sv
test/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f all.f -o tb_icache_sim

out=$(./obj_dir/tb_icache_sim || true)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                i_rvalid,
    input  logic [31:0]                         i_raddr,
    input  logic                                i_uncache,
    input  logic [icache_pkg::cookie_width-1:0] i_cookie,
    input  logic                                i_cacop_en,
    input  icache_pkg::cacop_op_e               i_cacop_code,
    input  logic [icache_pkg::num_ways-1:0]     i_way_hit,
    input  logic                                i_mem_rready,
    output logic                                o_rready,
    output logic [31:0]                         o_pc,
    output logic [icache_pkg::cookie_width-1:0] o_cookie,
    output logic [icache_pkg::exc_width-1:0]    o_exception,
    output logic [31:0]                         o_badv,
    output logic                                o_cacop_ready,
    output logic                                o_cacop_done,
    output logic                                o_mem_rvalid,
    output logic [31:0]                         o_mem_raddr,
    output logic [icache_pkg::index_width-1:0]  o_rd_index,
    output logic [icache_pkg::index_width-1:0]  o_wr_index,
    output logic [icache_pkg::tag_width-1:0]    o_wr_tag,
    output logic [icache_pkg::tag_width-1:0]    o_lookup_tag,
    output logic [icache_pkg::num_ways-1:0]     o_way_we,
    output logic                                o_way_clear,
    output logic                                o_from_refill,
    output logic                                o_uncache,
    output logic [2:0]                          o_dw_sel
);
    import icache_pkg::*;

    logic [31:0]             req_q;
    logic [cookie_width-1:0] cookie_q;
    logic                    uncache_q;
    logic                    cacop_q;
    cacop_op_e               cacop_code_q;
    icache_state_e           state_q, state_d;
    logic [num_sets-1:0]     lru_q;        // way to evict next in each set
    logic [index_width-1:0]  req_index;
    logic [num_ways-1:0]     victim_mask;
    logic                    is_adef;
    logic                    cache_hit;
    logic                    ready;
    logic                    accept;
    logic                    lru_we;
    logic                    lru_way;      // way just used

    assign accept    = ready && (i_rvalid || i_cacop_en);
    assign req_index = req_q[offset_width +: index_width];
    assign cache_hit = |i_way_hit;

    // request buffers
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q    <= i_raddr;
            cookie_q <= i_cookie;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncache_q    <= 1'b0;
            cacop_q      <= 1'b0;
            cacop_code_q <= op_store_tag;
        end else if (accept) begin
            uncache_q    <= i_uncache && !i_cacop_en;
            cacop_q      <= i_cacop_en;   // cacop wins over a fetch
            cacop_code_q <= i_cacop_code;
        end
    end

    // misaligned fetch is never raised for a cache op
    assign is_adef     = !cacop_q && (req_q[1:0] != 2'b00);
    assign o_exception = is_adef ? exc_adef : exc_none;
    assign o_badv      = is_adef ? req_q : 32'h0;

    always_comb begin
        victim_mask = '0;
        if (cacop_q) begin
            case (cacop_code_q)
                op_store_tag, op_index_inv: victim_mask[req_q[0]] = 1'b1; // way from addr bit 0
                op_hit_inv:                 victim_mask = i_way_hit;
                default:                    victim_mask = '0;
            endcase
        end else begin
            victim_mask[lru_q[req_index]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (lru_we) begin
            lru_q[req_index] <= ~lru_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        ready        = 1'b0;
        o_rready     = 1'b0;
        o_mem_rvalid = 1'b0;
        o_cacop_done = 1'b0;
        o_way_we     = '0;
        o_way_clear  = 1'b0;
        lru_we       = 1'b0;
        lru_way      = 1'b0;
        case (state_q)
            st_idle: begin
                ready = 1'b1;
            end
            st_lookup: begin
                if (is_adef) begin
                    o_rready = 1'b1;
                    state_d  = st_idle;
                end else if (uncache_q || !cache_hit) begin
                    state_d = st_miss;
                end else begin
                    o_rready = 1'b1;
                    ready    = 1'b1;
                    lru_we   = 1'b1;
                    lru_way  = i_way_hit[1];
                    state_d  = st_idle;
                end
            end
            st_miss: begin
                o_mem_rvalid = 1'b1;
                if (i_mem_rready) state_d = st_refill;
            end
            st_refill: begin
                ready   = 1'b1;
                state_d = st_idle;
                if (cacop_q) begin
                    o_cacop_done = 1'b1;
                end else begin
                    o_rready = 1'b1;
                    if (!uncache_q) begin // allocate into the LRU victim
                        o_way_we = victim_mask;
                        lru_we   = 1'b1;
                        lru_way  = lru_q[req_index];
                    end
                end
            end
            st_cacop: begin
                o_way_clear = 1'b1;
                o_way_we    = victim_mask;
                state_d     = st_refill;
            end
            default: state_d = st_idle;
        endcase
        if (accept) state_d = i_cacop_en ? st_cacop : st_lookup;
    end

    assign o_cacop_ready = ready;
    assign o_pc          = req_q;
    assign o_cookie      = cookie_q;
    assign o_mem_raddr   = uncache_q ? {req_q[31:3], 3'b000} : {req_q[31:6], 6'b000000};
    assign o_rd_index    = i_raddr[offset_width +: index_width]; // read at acceptance
    assign o_wr_index    = req_index;
    assign o_wr_tag      = req_q[31 -: tag_width];
    assign o_lookup_tag  = req_q[31 -: tag_width];
    assign o_from_refill = (state_q == st_refill);
    assign o_uncache     = uncache_q;
    assign o_dw_sel      = req_q[5:3];

    // memory request holds with a stable address until taken
    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int num_ways     = 2;
    localparam int index_width  = 6;
    localparam int offset_width = 6;
    localparam int tag_width    = 20;                 // addr[31:12]
    localparam int num_sets     = 1 << index_width;
    localparam int line_bits    = 512;
    localparam int cookie_width = 32;

    // exception codes
    localparam int exc_width = 7;
    localparam logic [exc_width-1:0] exc_none = 7'h00;
    localparam logic [exc_width-1:0] exc_adef = 7'h08; // fetch address error

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_refill,
        st_cacop
    } icache_state_e;

    // cache operation codes
    typedef enum logic [1:0] {
        op_store_tag = 2'b00,
        op_index_inv = 2'b01,
        op_hit_inv   = 2'b10
    } cacop_op_e;

endpackage

// File: source/icache_resp.sv
`timescale 1ns/1ps

module icache_resp (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [icache_pkg::line_bits-1:0] i_way_line [icache_pkg::num_ways],
    input  logic [icache_pkg::num_ways-1:0]  i_way_hit,
    input  logic                             i_mem_rready,
    input  logic [icache_pkg::line_bits-1:0] i_mem_rdata,
    input  logic                             i_from_refill,
    input  logic                             i_uncache,
    input  logic [2:0]                       i_dw_sel,
    output logic [icache_pkg::line_bits-1:0] o_fill_line,
    output logic [63:0]                      o_rdata
);
    import icache_pkg::*;

    logic [line_bits-1:0] ret_q;      // return buffer
    logic [line_bits-1:0] hit_line;
    logic [line_bits-1:0] sel_line;

    always_ff @(posedge clk) begin
        if (i_mem_rready) ret_q <= i_mem_rdata;
    end

    // and-or mux over the hit vector
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (i_way_hit[w]) hit_line = hit_line | i_way_line[w];
        end
    end

    assign sel_line    = i_from_refill ? ret_q : hit_line;
    assign o_rdata     = i_uncache ? sel_line[63:0] : sel_line[i_dw_sel*64 +: 64];
    assign o_fill_line = ret_q;

    // a tag lives in one way of a set only
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(i_way_hit));

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                i_rvalid,
    input  logic [31:0]                         i_raddr,
    input  logic                                i_uncache,
    input  logic [icache_pkg::cookie_width-1:0] i_cookie,
    input  logic                                i_cacop_en,
    input  icache_pkg::cacop_op_e               i_cacop_code,
    output logic                                o_rready,
    output logic [63:0]                         o_rdata,
    output logic [31:0]                         o_pc,
    output logic [icache_pkg::cookie_width-1:0] o_cookie,
    output logic [icache_pkg::exc_width-1:0]    o_exception,
    output logic [31:0]                         o_badv,
    output logic                                o_cacop_ready,
    output logic                                o_cacop_done,
    output logic                                o_mem_rvalid,
    output logic [31:0]                         o_mem_raddr,
    input  logic                                i_mem_rready,
    input  logic [icache_pkg::line_bits-1:0]    i_mem_rdata
);
    import icache_pkg::*;

    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   wr_tag;
    logic [tag_width-1:0]   lookup_tag;
    logic [num_ways-1:0]    way_we;
    logic [num_ways-1:0]    way_hit;
    logic [line_bits-1:0]   way_line [num_ways];
    logic [line_bits-1:0]   fill_line;
    logic                   way_clear;
    logic                   from_refill;
    logic                   uncache;
    logic [2:0]             dw_sel;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_raddr       (i_raddr),
        .i_uncache     (i_uncache),
        .i_cookie      (i_cookie),
        .i_cacop_en    (i_cacop_en),
        .i_cacop_code  (i_cacop_code),
        .i_way_hit     (way_hit),
        .i_mem_rready  (i_mem_rready),
        .o_rready      (o_rready),
        .o_pc          (o_pc),
        .o_cookie      (o_cookie),
        .o_exception   (o_exception),
        .o_badv        (o_badv),
        .o_cacop_ready (o_cacop_ready),
        .o_cacop_done  (o_cacop_done),
        .o_mem_rvalid  (o_mem_rvalid),
        .o_mem_raddr   (o_mem_raddr),
        .o_rd_index    (rd_index),
        .o_wr_index    (wr_index),
        .o_wr_tag      (wr_tag),
        .o_lookup_tag  (lookup_tag),
        .o_way_we      (way_we),
        .o_way_clear   (way_clear),
        .o_from_refill (from_refill),
        .o_uncache     (uncache),
        .o_dw_sel      (dw_sel)
    );

    for (genvar g = 0; g < num_ways; g++) begin : g_way
        icache_way u_way (
            .clk          (clk),
            .rstn         (rstn),
            .i_rd_index   (rd_index),
            .i_wr_index   (wr_index),
            .i_we         (way_we[g]),
            .i_clear      (way_clear),
            .i_wr_tag     (wr_tag),
            .i_lookup_tag (lookup_tag),
            .i_fill_line  (fill_line),
            .o_hit        (way_hit[g]),
            .o_line       (way_line[g])
        );
    end

    icache_resp u_resp (
        .clk           (clk),
        .rstn          (rstn),
        .i_way_line    (way_line),
        .i_way_hit     (way_hit),
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata),
        .i_from_refill (from_refill),
        .i_uncache     (uncache),
        .i_dw_sel      (dw_sel),
        .o_fill_line   (fill_line),
        .o_rdata       (o_rdata)
    );

endmodule

// File: source/icache_way.sv
`timescale 1ns/1ps

module icache_way (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [icache_pkg::index_width-1:0] i_rd_index,
    input  logic [icache_pkg::index_width-1:0] i_wr_index,
    input  logic                               i_we,
    input  logic                               i_clear,      // write clears the valid bit
    input  logic [icache_pkg::tag_width-1:0]   i_wr_tag,
    input  logic [icache_pkg::tag_width-1:0]   i_lookup_tag,
    input  logic [icache_pkg::line_bits-1:0]   i_fill_line,
    output logic                               o_hit,
    output logic [icache_pkg::line_bits-1:0]   o_line
);
    import icache_pkg::*;

    logic [num_sets-1:0]  valid_q;
    logic [tag_width-1:0] tag_mem  [num_sets];
    logic [line_bits-1:0] line_mem [num_sets];
    logic [tag_width-1:0] tag_rd_q;
    logic                 valid_rd_q;
    logic                 same_index;

    assign same_index = i_we && (i_wr_index == i_rd_index);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_wr_index] <= !i_clear;
        end
    end

    // tag and line only change on a fill
    always_ff @(posedge clk) begin
        if (i_we && !i_clear) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_fill_line;
        end
    end

    // synchronous read that is write-first on an index collision
    always_ff @(posedge clk) begin
        if (same_index && !i_clear) begin
            tag_rd_q <= i_wr_tag;
            o_line   <= i_fill_line;
        end else begin
            tag_rd_q <= tag_mem[i_rd_index];
            o_line   <= line_mem[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_rd_q <= 1'b0;
        end else if (same_index) begin
            valid_rd_q <= !i_clear;
        end else begin
            valid_rd_q <= valid_q[i_rd_index];
        end
    end

    assign o_hit = valid_rd_q && (tag_rd_q == i_lookup_tag);

endmodule

// File: test/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter int unsigned seed      = 32'h1,
    parameter int          min_delay = 1,
    parameter int          max_delay = 6,
    parameter logic [31:0] word_key  = 32'h0
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             i_mem_rvalid,
    input  logic [31:0]                      i_mem_raddr,
    output logic                             o_mem_rready,
    output logic [icache_pkg::line_bits-1:0] o_mem_rdata,
    output int                               o_req_count,
    output logic [31:0]                      o_last_raddr
);
    import icache_pkg::*;

    // words counted up from the request address, so bits 63:0 hold the first doubleword
    function automatic logic [line_bits-1:0] line_from(input logic [31:0] base);
        logic [line_bits-1:0] line;
        line = '0;
        for (int k = 0; k < line_bits / 32; k++) begin
            line[32*k +: 32] = (base + 32'(4 * k)) ^ word_key;
        end
        return line;
    endfunction

    initial begin
        int unsigned delay;
        delay        = $urandom(seed);   // seeds the generator once
        o_mem_rready = 1'b0;
        o_mem_rdata  = '0;
        o_req_count  = 0;
        o_last_raddr = '0;
        forever begin
            @(negedge clk);
            o_mem_rready = 1'b0;
            if (rstn && i_mem_rvalid) begin
                delay = min_delay + ($urandom % (max_delay - min_delay + 1));
                repeat (delay) @(negedge clk);
                o_last_raddr = i_mem_raddr;
                o_mem_rdata  = line_from(i_mem_raddr);
                o_mem_rready = 1'b1;              // one-cycle beat
                o_req_count  = o_req_count + 1;
            end
        end
    end

endmodule

// File: test/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int          clk_half      = 4;
    localparam int unsigned rand_seed     = 32'h8ca6_9d29;
    localparam int          mem_min_delay = 1;
    localparam int          mem_max_delay = 6;
    localparam int          wait_limit    = 200;
    localparam logic [31:0] word_key      = 32'hc0de_0000;

    logic                 clk;
    logic                 rstn;
    logic                 rvalid;
    logic [31:0]          raddr;
    logic                 uncache;
    logic [31:0]          req_cookie;
    logic                 cacop_en;
    cacop_op_e            cacop_code;
    logic                 rready;
    logic [63:0]          rdata;
    logic [31:0]          pc;
    logic [31:0]          cookie;
    logic [exc_width-1:0] exception;
    logic [31:0]          badv;
    logic                 cacop_ready;
    logic                 cacop_done;
    logic                 mem_rvalid;
    logic [31:0]          mem_raddr;
    logic                 mem_rready;
    logic [line_bits-1:0] mem_rdata;
    int                   req_count;
    logic [31:0]          last_raddr;
    int                   cookie_seq;

    always #(clk_half) clk = ~clk;

    icache_top u_icache_top (
        .clk (clk), .rstn (rstn),
        .i_rvalid (rvalid), .i_raddr (raddr), .i_uncache (uncache), .i_cookie (req_cookie),
        .i_cacop_en (cacop_en), .i_cacop_code (cacop_code),
        .o_rready (rready), .o_rdata (rdata), .o_pc (pc), .o_cookie (cookie),
        .o_exception (exception), .o_badv (badv),
        .o_cacop_ready (cacop_ready), .o_cacop_done (cacop_done),
        .o_mem_rvalid (mem_rvalid), .o_mem_raddr (mem_raddr),
        .i_mem_rready (mem_rready), .i_mem_rdata (mem_rdata)
    );

    icache_mem_model #(
        .seed (rand_seed), .min_delay (mem_min_delay), .max_delay (mem_max_delay),
        .word_key (word_key)
    ) u_mem (
        .clk (clk), .rstn (rstn), .i_mem_rvalid (mem_rvalid), .i_mem_raddr (mem_raddr),
        .o_mem_rready (mem_rready), .o_mem_rdata (mem_rdata),
        .o_req_count (req_count), .o_last_raddr (last_raddr)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            report_failure($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // doubleword that holds byte address a by the word rule a ^ key
    function automatic logic [63:0] expected_dword(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ word_key, base ^ word_key};
    endfunction

    task automatic expect_quiet_outputs();
        check_value("o_rready", 64'(rready), 64'd0);
        check_value("o_mem_rvalid", 64'(mem_rvalid), 64'd0);
        check_value("o_cacop_done", 64'(cacop_done), 64'd0);
    endtask

    // one fetch from idle; exp_reqs is the number of memory requests it must make
    task automatic fetch(input logic [31:0] addr, input logic uc, input int exp_reqs);
        int          cycles;
        int          reqs_before;
        logic [31:0] ck;
        logic [31:0] exp_maddr;
        reqs_before = req_count;
        cookie_seq  = cookie_seq + 1;
        ck          = 32'hc00c_0000 + 32'(cookie_seq);
        exp_maddr   = uc ? (addr & ~32'h7) : (addr & ~32'h3f);
        rvalid      = 1'b1;
        raddr       = addr;
        uncache     = uc;
        req_cookie  = ck;
        @(negedge clk);
        rvalid = 1'b0;
        cycles = 1;
        while (!rready && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (rready) else report_failure("timed out waiting for a fetch response");
        check_value("o_pc", 64'(pc), 64'(addr));
        check_value("o_cookie", 64'(cookie), 64'(ck));
        if (addr[1:0] != 2'b00) begin
            check_value("o_exception", 64'(exception), 64'(exc_adef));
            check_value("o_badv", 64'(badv), 64'(addr));
        end else begin
            check_value("o_exception", 64'(exception), 64'(exc_none));
            check_value("o_rdata", rdata, expected_dword(addr));
        end
        check_value("memory requests", 64'(req_count - reqs_before), 64'(exp_reqs));
        if (exp_reqs > 0) check_value("o_mem_raddr", 64'(last_raddr), 64'(exp_maddr));
        else check_value("response cycles", 64'(cycles), 64'd1);  // answered in lookup
        @(negedge clk);
    endtask

    task automatic cache_op(input cacop_op_e op, input logic [31:0] addr);
        int cycles;
        assert (cacop_ready) else report_failure("cache not ready for a cache operation");
        cacop_en   = 1'b1;
        cacop_code = op;
        raddr      = addr;
        @(negedge clk);
        cacop_en = 1'b0;
        cycles   = 1;
        while (!cacop_done && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (cacop_done) else report_failure("timed out waiting for o_cacop_done");
        check_value("cacop cycles", 64'(cycles), 64'd2);
        check_value("o_rready", 64'(rready), 64'd0);   // no fetch response for a cacop
        @(negedge clk);
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        rvalid     = 1'b0;
        raddr      = '0;
        uncache    = 1'b0;
        req_cookie = '0;
        cacop_en   = 1'b0;
        cacop_code = op_store_tag;
        cookie_seq = 0;
        repeat (10) begin
            @(negedge clk);
            expect_quiet_outputs();
        end
        rstn = 1'b1;
        @(negedge clk);
        expect_quiet_outputs();

        // miss, then every doubleword of the line hits
        fetch(32'h0000_1040, 1'b0, 1);
        for (int dw = 0; dw < 8; dw++) fetch(32'h0000_1040 + 32'(8 * dw), 1'b0, 0);

        // set 2 gets A, B, A again, then C takes B's way
        fetch(32'h0001_0080, 1'b0, 1);
        fetch(32'h0002_0080, 1'b0, 1);
        fetch(32'h0001_0080, 1'b0, 0);
        fetch(32'h0003_0080, 1'b0, 1);
        fetch(32'h0001_0080, 1'b0, 0);
        fetch(32'h0002_0080, 1'b0, 1);

        // uncached never allocates
        fetch(32'h0004_00cc, 1'b1, 1);
        fetch(32'h0004_00cc, 1'b1, 1);
        fetch(32'h0004_00cc, 1'b0, 1);
        fetch(32'h0004_00cc, 1'b0, 0);

        fetch(32'h0005_0102, 1'b0, 0);  // misaligned
        fetch(32'h0005_0103, 1'b0, 0);

        // in set 4 X lands in way 0 and Y in way 1
        fetch(32'h0006_0100, 1'b0, 1);
        fetch(32'h0007_0100, 1'b0, 1);
        cache_op(op_index_inv, 32'h0000_0101);  // bit 0 picks way 1
        fetch(32'h0006_0100, 1'b0, 0);
        fetch(32'h0007_0100, 1'b0, 1);
        cache_op(op_store_tag, 32'h0000_0100);  // way 0
        fetch(32'h0007_0100, 1'b0, 0);
        fetch(32'h0006_0100, 1'b0, 1);
        cache_op(op_hit_inv, 32'h0007_0100);    // Y is in way 1 while addr bit 0 names way 0
        fetch(32'h0006_0100, 1'b0, 0);
        fetch(32'h0007_0100, 1'b0, 1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
